// File: dcache.f
common/dcache_pkg.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_controller.sv
source/dcache.sv
sim/tb_clock_gen.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - common/dcache_pkg.sv
  - dcache/dcache_tag_store.sv
  - dcache/dcache_data_store.sv
  - dcache/dcache_controller.sv
  - source/dcache.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/dcache_checker.sv
      - sim/dcache_tb.sv

// File: sim/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int INDEX_BITS   = 8;
    localparam int LINES        = 2 ** INDEX_BITS;
    localparam int BLOCK_BITS   = dcache_pkg::ADDR_WIDTH - dcache_pkg::WORD_SEL_BITS
                                - dcache_pkg::BYTE_OFFSET_BITS;
    localparam int NUM_RANDOM   = 2000;
    localparam int MAX_REQUESTS = NUM_RANDOM + 200; // Directed tests and flush included

    logic clk;
    logic RESET;
    logic en, we, hold, mem_en, mem_we, mem_hold;
    dcache_pkg::addr_t    addr;
    dcache_pkg::word_t    din, dout;
    dcache_pkg::byte_en_t be;
    logic [BLOCK_BITS-1:0] mem_baddr;
    dcache_pkg::line_t    mem_din, mem_dout;

    tb_clock_gen clock_gen (.clk(clk), .RESET(RESET));

    dcache #(.INDEX_BITS(INDEX_BITS)) DUT (
        .clk(clk), .RESET(RESET),
        .en(en), .we(we), .addr(addr), .din(din), .be(be), .dout(dout), .hold(hold),
        .mem_en(mem_en), .mem_we(mem_we), .mem_baddr(mem_baddr), .mem_din(mem_din),
        .mem_dout(mem_dout), .mem_hold(mem_hold)
    );

    bind dcache dcache_checker protocol_check (
        .clk(clk), .RESET(RESET), .en(en), .hold(hold), .dout(dout),
        .mem_en(mem_en), .mem_we(mem_we), .mem_baddr(mem_baddr), .mem_din(mem_din),
        .mem_hold(mem_hold)
    );

    logic [31:0]           lfsr = 32'h328;
    logic [7:0]            model_mem [dcache_pkg::addr_t];  // Bytes the CPU has written
    dcache_pkg::line_t     mem_lines [logic [BLOCK_BITS-1:0]];
    logic [BLOCK_BITS-1:0] res_blk [LINES];                 // Expected cache contents
    bit                    res_valid [LINES];
    bit                    res_dirty [LINES];
    int                    delay_q [$];
    logic [BLOCK_BITS-1:0] exp_wb_blk, exp_rd_blk;
    int  wb_count, rd_count, wait_cnt;
    int  checks = 0;
    int  errors = 0;
    int  test_errors = 0;
    bit  active, long_delays;
    dcache_pkg::addr_t a;
    logic [BLOCK_BITS-1:0] blk;

    ////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    // Preset memory word that differs for every address
    function automatic dcache_pkg::word_t preset_word(dcache_pkg::addr_t wa);
        return {wa[31:16] ^ wa[15:0], wa[15:0] ^ 16'h5A5A};
    endfunction

    function automatic dcache_pkg::line_t preset_line(logic [BLOCK_BITS-1:0] b);
        dcache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = preset_word({b, 2'(w), 2'b00});
        end
        return l;
    endfunction

    function automatic dcache_pkg::line_t model_line(logic [BLOCK_BITS-1:0] b);
        dcache_pkg::line_t l;
        l = preset_line(b);
        for (int i = 0; i < 16; i++) begin
            if (model_mem.exists({b, 4'(i)})) l[i*8 +: 8] = model_mem[{b, 4'(i)}];
        end
        return l;
    endfunction

    // Small pool of tags and indices so lines keep colliding
    function automatic dcache_pkg::addr_t pool_addr();
        logic [1:0] t, i, w;
        t = 2'(rand_bits(2));
        i = 2'(rand_bits(2));
        w = 2'(rand_bits(2));
        return {18'h12345, t, i, 6'h15, w, 2'b00};
    endfunction

    task automatic check_value(string name, logic [127:0] expected, logic [127:0] got);
        checks++;
        assert (expected === got) else begin
            $display("error %s expected %0h got %0h", name, expected, got);
            test_errors++;
        end
    endtask

    task automatic check_true(bit ok, string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////
    // Memory responder
    ////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (RESET) begin
            mem_hold <= 1'b1;
            active = 1'b0;
        end else if (mem_en && !mem_hold) begin // Transfer ends on this edge
            mem_hold <= 1'b1;
            active = 1'b0;
            if (mem_we) begin
                wb_count++;
                check_value("mem_baddr", exp_wb_blk, mem_baddr);
                check_value("mem_din", model_line(exp_wb_blk), mem_din);
                mem_lines[mem_baddr] = mem_din;
            end else begin
                rd_count++;
                check_value("mem_baddr", exp_rd_blk, mem_baddr);
            end
        end else if (mem_en) begin
            if (!active) begin
                active   = 1'b1;
                wait_cnt = (delay_q.size() > 0) ? delay_q.pop_front() : 0;
            end
            if (wait_cnt == 0) begin
                mem_hold <= 1'b0;
                mem_dout <= mem_lines.exists(mem_baddr) ? mem_lines[mem_baddr]
                                                        : preset_line(mem_baddr);
            end else begin
                wait_cnt--;
            end
        end
    end

    ////////////////////////////////////////////////////
    // CPU requests
    ////////////////////////////////////////////////////

    task automatic run_request(bit wr, dcache_pkg::addr_t ra);
        logic [BLOCK_BITS-1:0] rb;
        logic [INDEX_BITS-1:0] idx;
        bit                    hit, exp_wb;
        int                    cycles;
        dcache_pkg::word_t     d;
        dcache_pkg::byte_en_t  b;
        dcache_pkg::line_t     l;
        rb  = ra[31:4];
        idx = ra[4 +: INDEX_BITS];
        d   = rand_bits(32);
        b   = 4'(rand_bits(4));
        hit        = res_valid[idx] && res_blk[idx] == rb;
        exp_wb     = !hit && res_valid[idx] && res_dirty[idx];
        exp_wb_blk = res_blk[idx];
        exp_rd_blk = rb;
        wb_count   = 0;
        rd_count   = 0;
        repeat (int'(exp_wb) + int'(!hit)) begin
            delay_q.push_back(long_delays ? 7 : int'(rand_bits(3)));
        end
        @(posedge clk);
        en   <= 1'b1;
        we   <= wr;
        addr <= ra;
        din  <= d;
        be   <= b;
        cycles = 0;
        @(negedge clk);
        while (hold) begin
            cycles++;
            @(negedge clk);
        end
        check_true(wb_count == int'(exp_wb) && rd_count == int'(!hit),
            $sformatf("request to %h made %0d memory writes and %0d reads",
                      ra, wb_count, rd_count));
        check_true(!hit || cycles == 2, $sformatf("hit on %h took %0d cycles", ra, cycles));
        check_true(!mem_en, "memory transfer still open when the request completed");
        l = model_line(rb);
        if (!wr) begin
            check_value("dout", l[ra[3:2]*32 +: 32], dout);
        end
        for (int i = 0; i < 4; i++) begin
            if (wr && b[i]) model_mem[{ra[31:2], 2'(i)}] = d[i*8 +: 8];
        end
        res_dirty[idx] = (hit && res_dirty[idx]) || wr; // Any write dirties the line
        res_valid[idx] = 1'b1;
        res_blk[idx]   = rb;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        en <= 1'b0;
    endtask

    task automatic end_test(string name);
        $display("test %s: %0d errors", name, test_errors);
        errors      += test_errors;
        test_errors  = 0;
    endtask

    ////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////

    initial begin
        en       = 1'b0;
        we       = 1'b0;
        addr     = '0;
        din      = '0;
        be       = '0;
        mem_hold = 1'b1;
        mem_dout = '0;
        @(negedge RESET);
        @(negedge clk);
        check_value("hold", 0, hold);
        check_value("mem_en", 0, mem_en);
        run_request(1'b0, pool_addr()); // Cold miss
        end_test("reset_state");

        a = pool_addr();
        run_request(1'b0, a);
        run_request(1'b1, a);
        run_request(1'b0, a);
        end_test("read_after_write_hit");

        a = pool_addr();
        run_request(1'b1, a);
        run_request(1'b0, {a[31:12] ^ 20'h1, a[11:0]}); // Same index, other tag
        end_test("dirty_eviction");

        a = pool_addr();
        a = {20'hABCDE, a[11:0]};
        run_request(1'b1, a);
        for (int w = 0; w < 4; w++) begin
            run_request(1'b0, {a[31:4], 2'(w), 2'b00});
        end
        end_test("write_miss_allocation");

        long_delays = 1'b1;
        repeat (64) run_request(1'(rand_bits(1)), pool_addr());
        long_delays = 1'b0;
        end_test("back_pressure");

        repeat (NUM_RANDOM) begin
            run_request(1'(rand_bits(1)), pool_addr());
            if (rand_bits(2) == 0) idle_cycle();
        end
        // Conflicting reads push every dirty line out
        for (int i = 0; i < 4; i++) begin
            run_request(1'b0, {20'hFFFFF, 2'(i), 6'h15, 4'h0});
        end
        idle_cycle();
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 4; i++) begin
                blk = {18'h12345, 2'(t), 2'(i), 6'h15};
                check_value("memory line", model_line(blk),
                    mem_lines.exists(blk) ? mem_lines[blk] : preset_line(blk));
            end
        end
        end_test("random_mix");

        $display("%0d checks, %0d errors, %0d protocol failures",
                 checks, errors, DUT.protocol_check.failures);
        if (errors == 0 && DUT.protocol_check.failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per request
    initial begin
        #(MAX_REQUESTS * 40 * 8);
        $display("timeout: the requests did not complete in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input wire logic              clk,
    input wire logic              RESET,
    input wire logic              en,
    input wire logic              hold,
    input wire dcache_pkg::word_t dout,
    input wire logic              mem_en,
    input wire logic              mem_we,
    input wire logic [dcache_pkg::ADDR_WIDTH-dcache_pkg::WORD_SEL_BITS
                      -dcache_pkg::BYTE_OFFSET_BITS-1:0] mem_baddr,
    input wire dcache_pkg::line_t mem_din,
    input wire logic              mem_hold
);

    int failures = 0;

    ////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////

    mem_stable: assert property (@(posedge clk) disable iff (RESET)
        mem_en && mem_hold |=> mem_en && $stable(mem_we) && $stable(mem_baddr)
                               && $stable(mem_din))
    else begin
        $error("memory request changed while mem_hold was high");
        failures++;
    end

    mem_release: assert property (@(posedge clk) disable iff (RESET)
        mem_en && !mem_hold |=> !mem_en) // One transfer per mem_en pulse
    else begin
        $error("mem_en stayed high after the transfer ended");
        failures++;
    end

    ////////////////////////////////////////////////////
    // CPU port
    ////////////////////////////////////////////////////

    reset_idle: assert property (@(posedge clk)
        $fell(RESET) |-> !hold && !mem_en && !mem_we)
    else begin
        $error("port not idle when reset was released");
        failures++;
    end

    // Last result stays put between requests
    dout_kept: assert property (@(posedge clk) disable iff (RESET)
        !hold && !en && !$isunknown(dout) |=> $stable(dout))
    else begin
        $error("dout changed with no request pending");
        failures++;
    end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic RESET
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held for RESET_CYCLES rising edges
    initial begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        RESET <= 1'b0;
    end

endmodule

`default_nettype wire

// File: source/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache #(
    parameter int INDEX_BITS = 8
) (
    input  logic                 clk,
    input  logic                 RESET,

    // CPU port
    input  logic                 en,
    input  logic                 we,
    input  dcache_pkg::addr_t    addr,
    input  dcache_pkg::word_t    din,
    input  dcache_pkg::byte_en_t be,
    output dcache_pkg::word_t    dout,
    output logic                 hold,

    // Memory port moves one block per transfer
    output logic                 mem_en,
    output logic                 mem_we,
    output logic [dcache_pkg::ADDR_WIDTH-dcache_pkg::WORD_SEL_BITS
                  -dcache_pkg::BYTE_OFFSET_BITS-1:0] mem_baddr,
    output dcache_pkg::line_t    mem_din,
    input  dcache_pkg::line_t    mem_dout,
    input  logic                 mem_hold
);

    localparam int TAG_BITS = dcache_pkg::ADDR_WIDTH - INDEX_BITS
                            - dcache_pkg::WORD_SEL_BITS - dcache_pkg::BYTE_OFFSET_BITS;

    ////////////////////////////////////////////////////
    // Controller to stores
    ////////////////////////////////////////////////////

    logic [INDEX_BITS-1:0] tag_index;
    logic                  tag_we;
    logic [TAG_BITS-1:0]   tag_wr;
    logic                  dirty_wr;
    logic [TAG_BITS-1:0]   tag_rd;
    logic                  valid_rd;
    logic                  dirty_rd;

    logic [INDEX_BITS-1:0]  line_index;
    logic                   line_we;
    logic                   word_we;
    dcache_pkg::word_sel_t  word_sel;
    dcache_pkg::byte_en_t   word_be;
    dcache_pkg::line_t      line_wr;
    dcache_pkg::line_t      line_rd;

    dcache_controller #(.INDEX_BITS(INDEX_BITS)) controller (
        .clk(clk), .RESET(RESET),
        .en(en), .we(we), .addr(addr), .din(din), .be(be), .dout(dout), .hold(hold),
        .mem_en(mem_en), .mem_we(mem_we), .mem_baddr(mem_baddr), .mem_din(mem_din),
        .mem_dout(mem_dout), .mem_hold(mem_hold),
        .tag_index(tag_index), .tag_we(tag_we), .tag_wr(tag_wr), .dirty_wr(dirty_wr),
        .tag_rd(tag_rd), .valid_rd(valid_rd), .dirty_rd(dirty_rd),
        .line_index(line_index), .line_we(line_we), .word_we(word_we),
        .word_sel(word_sel), .word_be(word_be), .line_wr(line_wr), .line_rd(line_rd)
    );

    dcache_tag_store #(.INDEX_BITS(INDEX_BITS)) tag_store (
        .clk(clk), .RESET(RESET),
        .tag_index(tag_index), .tag_we(tag_we), .tag_wr(tag_wr), .dirty_wr(dirty_wr),
        .tag_rd(tag_rd), .valid_rd(valid_rd), .dirty_rd(dirty_rd)
    );

    dcache_data_store #(.INDEX_BITS(INDEX_BITS)) data_store (
        .clk(clk),
        .line_index(line_index), .line_we(line_we), .word_we(word_we),
        .word_sel(word_sel), .word_be(word_be), .line_wr(line_wr), .line_rd(line_rd)
    );

endmodule

`default_nettype wire

// File: dcache/dcache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_controller #(
    parameter int INDEX_BITS = 8
) (
    input  logic                  clk,
    input  logic                  RESET,

    // CPU side
    input  logic                  en,
    input  logic                  we,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::word_t     din,
    input  dcache_pkg::byte_en_t  be,
    output dcache_pkg::word_t     dout,
    output logic                  hold,

    // Memory side
    output logic                  mem_en,
    output logic                  mem_we,
    output logic [dcache_pkg::ADDR_WIDTH-dcache_pkg::WORD_SEL_BITS
                  -dcache_pkg::BYTE_OFFSET_BITS-1:0] mem_baddr,
    output dcache_pkg::line_t     mem_din,
    input  dcache_pkg::line_t     mem_dout,
    input  logic                  mem_hold,

    // Tag store
    output logic [INDEX_BITS-1:0] tag_index,
    output logic                  tag_we,
    output logic [dcache_pkg::ADDR_WIDTH-INDEX_BITS-dcache_pkg::WORD_SEL_BITS
                  -dcache_pkg::BYTE_OFFSET_BITS-1:0] tag_wr,
    output logic                  dirty_wr,
    input  logic [dcache_pkg::ADDR_WIDTH-INDEX_BITS-dcache_pkg::WORD_SEL_BITS
                  -dcache_pkg::BYTE_OFFSET_BITS-1:0] tag_rd,
    input  logic                  valid_rd,
    input  logic                  dirty_rd,

    // Data store
    output logic [INDEX_BITS-1:0] line_index,
    output logic                  line_we,
    output logic                  word_we,
    output dcache_pkg::word_sel_t word_sel,
    output dcache_pkg::byte_en_t  word_be,
    output dcache_pkg::line_t     line_wr,
    input  dcache_pkg::line_t     line_rd
);

    localparam int INDEX_LSB  = dcache_pkg::BYTE_OFFSET_BITS + dcache_pkg::WORD_SEL_BITS;
    localparam int TAG_BITS   = dcache_pkg::ADDR_WIDTH - INDEX_BITS - INDEX_LSB;
    localparam int BLOCK_BITS = dcache_pkg::ADDR_WIDTH - INDEX_LSB;
    localparam int WORD_BITS  = dcache_pkg::WORD_WIDTH;

    dcache_pkg::cache_state_t state, next_state;

    logic [INDEX_BITS-1:0] index_q;     // Index of the request in flight
    logic                  miss_q;      // Request went through memory
    dcache_pkg::line_t     fill_line;   // Block returned by memory
    dcache_pkg::line_t     merged_line;

    logic [TAG_BITS-1:0]   addr_tag;
    logic [BLOCK_BITS-1:0] addr_block;
    logic                  hit;
    logic                  victim_dirty;
    logic                  mem_done;

    assign addr_tag     = addr[dcache_pkg::ADDR_WIDTH-1 -: TAG_BITS];
    assign addr_block   = addr[dcache_pkg::ADDR_WIDTH-1 -: BLOCK_BITS];
    assign word_sel     = addr[dcache_pkg::BYTE_OFFSET_BITS +: dcache_pkg::WORD_SEL_BITS];
    assign hit          = valid_rd && (tag_rd == addr_tag);
    assign victim_dirty = valid_rd && dirty_rd;
    assign mem_done     = mem_en && !mem_hold; // Transfer accepted this cycle

    ////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (RESET) begin
            state <= dcache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::idle: begin
                if (en) begin
                    next_state = dcache_pkg::compare_tag;
                end
            end
            dcache_pkg::compare_tag: begin
                if (hit) begin
                    next_state = dcache_pkg::update;
                end else if (victim_dirty) begin
                    next_state = dcache_pkg::writeback;
                end else begin
                    next_state = dcache_pkg::allocate;
                end
            end
            dcache_pkg::writeback: begin
                if (mem_done) begin
                    next_state = dcache_pkg::allocate;
                end
            end
            dcache_pkg::allocate: begin
                if (mem_done) begin
                    next_state = dcache_pkg::update;
                end
            end
            default: next_state = dcache_pkg::idle; // update lasts one cycle
        endcase
    end

    // Only idle without a request and the update cycle let the CPU go
    always_comb begin
        case (state)
            dcache_pkg::idle:   hold = en;
            dcache_pkg::update: hold = 1'b0;
            default:            hold = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////
    // Memory handshake
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (RESET) begin
            mem_en <= 1'b0;
            mem_we <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::compare_tag: begin
                    miss_q <= !hit;
                    if (!hit) begin
                        mem_en <= 1'b1;
                        mem_we <= victim_dirty; // Victim goes out first
                    end
                end
                dcache_pkg::writeback: begin
                    if (mem_done) begin
                        mem_en <= 1'b0;
                        mem_we <= 1'b0;
                    end
                end
                dcache_pkg::allocate: begin
                    if (mem_done) begin
                        mem_en <= 1'b0;
                    end else if (!mem_en) begin
                        mem_en <= 1'b1; // Block read after a writeback
                    end
                end
                default: ;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        case (state)
            dcache_pkg::idle: begin
                if (en) begin
                    index_q <= addr[INDEX_LSB +: INDEX_BITS];
                end
            end
            dcache_pkg::compare_tag: begin
                dout    <= line_rd[word_sel*WORD_BITS +: WORD_BITS];
                mem_din <= line_rd;
                if (victim_dirty) begin
                    mem_baddr <= {tag_rd, index_q}; // Victim block
                end else begin
                    mem_baddr <= addr_block;
                end
            end
            dcache_pkg::writeback: begin
                if (mem_done) begin
                    mem_baddr <= addr_block;
                end
            end
            dcache_pkg::allocate: begin
                if (mem_done) begin
                    fill_line <= mem_dout;
                    dout      <= mem_dout[word_sel*WORD_BITS +: WORD_BITS];
                end
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////
    // Store updates
    ////////////////////////////////////////////////////

    // CPU bytes merged over the fetched block
    always_comb begin
        merged_line = fill_line;
        if (we) begin
            for (int b = 0; b < WORD_BITS/8; b++) begin
                if (be[b]) begin
                    merged_line[word_sel*WORD_BITS + b*8 +: 8] = din[b*8 +: 8];
                end
            end
        end
    end

    assign tag_index  = index_q;
    assign line_index = index_q;
    assign tag_wr     = addr_tag;
    assign dirty_wr   = we;       // Written line is dirty, a fresh fill is clean
    assign tag_we     = (state == dcache_pkg::update) && (miss_q || we);
    assign line_we    = (state == dcache_pkg::update) && miss_q;
    assign word_we    = (state == dcache_pkg::update) && !miss_q && we;
    assign word_be    = be;
    assign line_wr    = merged_line;

endmodule

`default_nettype wire

// File: dcache/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store #(
    parameter int INDEX_BITS = 8
) (
    input  logic                  clk,
    input  logic [INDEX_BITS-1:0] line_index,
    input  logic                  line_we,
    input  logic                  word_we,
    input  dcache_pkg::word_sel_t word_sel,
    input  dcache_pkg::byte_en_t  word_be,
    input  dcache_pkg::line_t     line_wr,
    output dcache_pkg::line_t     line_rd
);

    localparam int LINES     = 2 ** INDEX_BITS;
    localparam int WORD_BITS = dcache_pkg::WORD_WIDTH;
    localparam int BYTES     = WORD_BITS / 8;

    dcache_pkg::line_t lines [LINES];

    ////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (line_we) begin
            lines[line_index] <= line_wr; // Fill from memory
        end else if (word_we) begin
            // Store hit writes only the enabled bytes of one word
            for (int b = 0; b < BYTES; b++) begin
                if (word_be[b]) begin
                    lines[line_index][word_sel*WORD_BITS + b*8 +: 8] <=
                        line_wr[word_sel*WORD_BITS + b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////

    assign line_rd = lines[line_index]; // Combinational

endmodule

`default_nettype wire

// File: dcache/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store #(
    parameter int INDEX_BITS = 8
) (
    input  logic                  clk,
    input  logic                  RESET,
    input  logic [INDEX_BITS-1:0] tag_index,
    input  logic                  tag_we,
    input  logic [dcache_pkg::ADDR_WIDTH-INDEX_BITS-dcache_pkg::WORD_SEL_BITS
                  -dcache_pkg::BYTE_OFFSET_BITS-1:0] tag_wr,
    input  logic                  dirty_wr,
    output logic [dcache_pkg::ADDR_WIDTH-INDEX_BITS-dcache_pkg::WORD_SEL_BITS
                  -dcache_pkg::BYTE_OFFSET_BITS-1:0] tag_rd,
    output logic                  valid_rd,
    output logic                  dirty_rd
);

    localparam int TAG_BITS = dcache_pkg::ADDR_WIDTH - INDEX_BITS
                            - dcache_pkg::WORD_SEL_BITS - dcache_pkg::BYTE_OFFSET_BITS;
    localparam int LINES    = 2 ** INDEX_BITS;

    logic [TAG_BITS-1:0] tags [LINES];
    logic [LINES-1:0]    valid_bits;
    logic [LINES-1:0]    dirty_bits;

    // Tag payload
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[tag_index] <= tag_wr;
        end
    end

    // All lines invalid and clean out of reset
    always_ff @(posedge clk) begin
        if (RESET) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (tag_we) begin
            valid_bits[tag_index] <= 1'b1; // Any tag write makes the line valid
            dirty_bits[tag_index] <= dirty_wr;
        end
    end

    // Asynchronous read port
    assign tag_rd   = tags[tag_index];
    assign valid_rd = valid_bits[tag_index];
    assign dirty_rd = dirty_bits[tag_index];

endmodule

`default_nettype wire

// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////

    localparam int ADDR_WIDTH       = 32;
    localparam int WORD_WIDTH       = 32;
    localparam int WORDS_PER_LINE   = 4;
    localparam int LINE_WIDTH       = WORD_WIDTH * WORDS_PER_LINE; // 128
    localparam int BYTE_OFFSET_BITS = 2;
    localparam int WORD_SEL_BITS    = 2;

    ////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////

    typedef logic [ADDR_WIDTH-1:0]     addr_t;     // Byte address
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [LINE_WIDTH-1:0]     line_t;
    typedef logic [WORD_WIDTH/8-1:0]   byte_en_t;  // One bit per byte of a word
    typedef logic [WORD_SEL_BITS-1:0]  word_sel_t; // Word within a line

    // Controller states
    typedef enum logic [2:0] {
        idle,
        compare_tag,
        writeback,
        allocate,
        update
    } cache_state_t;

endpackage

`default_nettype wire
